// File: src/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    // Datapath and register index widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // First fetch address after reset
    localparam word_t RESET_PC = '0;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    // PASS_B serves lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        cpu_cfg_pkg::word_t instr;
        cpu_cfg_pkg::word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        cpu_cfg_pkg::word_t     pc_plus4;
        cpu_cfg_pkg::word_t     op_a;
        cpu_cfg_pkg::word_t     op_b;
        cpu_cfg_pkg::word_t     imm;
        cpu_cfg_pkg::reg_addr_t rs;
        cpu_cfg_pkg::reg_addr_t rt;
        cpu_cfg_pkg::reg_addr_t dest;
        alu_op_e                alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   beq;
        logic                   bne;
        logic                   jump;
        logic [25:0]            jump_index;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        cpu_cfg_pkg::word_t     result;
        cpu_cfg_pkg::word_t     store_data;
        cpu_cfg_pkg::reg_addr_t dest;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        cpu_cfg_pkg::word_t     result;
        cpu_cfg_pkg::reg_addr_t dest;
        logic                   reg_write;
    } mem_wb_t;

endpackage

// File: src/pipe_ctrl_if.sv
`timescale 1ns/10ps

interface pipe_ctrl_if;

    logic pc_stall;
    logic ifid_stall;
    logic ifid_flush;
    logic idex_stall;
    logic idex_flush;
    logic exmem_stall;
    logic memwb_stall;

    modport hazard (
        output pc_stall, ifid_stall, ifid_flush, idex_stall, idex_flush,
               exmem_stall, memwb_stall
    );

    modport stage (
        input pc_stall, ifid_stall, ifid_flush, idex_stall, idex_flush,
              exmem_stall, memwb_stall
    );

endinterface

// File: src/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // All-zero payload is a bubble with valid low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: src/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  isa_pkg::if_id_t    if_id_i,
    input  cpu_cfg_pkg::word_t rs_data_i,
    input  cpu_cfg_pkg::word_t rt_data_i,
    output isa_pkg::id_ex_t    id_ex_o
);

    import isa_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    logic [15:0] imm16;
    logic        legal;

    assign opcode = opcode_e'(if_id_i.instr[31:26]);
    assign funct  = funct_e'(if_id_i.instr[5:0]);
    assign imm16  = if_id_i.instr[15:0];

    always_comb begin
        id_ex_o            = '0;
        id_ex_o.pc_plus4   = if_id_i.pc_plus4;
        id_ex_o.op_a       = rs_data_i;
        id_ex_o.op_b       = rt_data_i;
        id_ex_o.imm        = {{16{imm16[15]}}, imm16};
        id_ex_o.rs         = if_id_i.instr[25:21];
        id_ex_o.rt         = if_id_i.instr[20:16];
        id_ex_o.dest       = if_id_i.instr[20:16];
        id_ex_o.jump_index = if_id_i.instr[25:0];
        legal              = 1'b1;

        case (opcode)
            OP_RTYPE: begin
                id_ex_o.dest      = if_id_i.instr[15:11];
                id_ex_o.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: id_ex_o.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_o.alu_op = ALU_SUB;
                    FN_AND:  id_ex_o.alu_op = ALU_AND;
                    FN_OR:   id_ex_o.alu_op = ALU_OR;
                    FN_SLT:  id_ex_o.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                id_ex_o.alu_op    = ALU_ADD;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.reg_write = 1'b1;
            end
            OP_LUI: begin
                id_ex_o.imm       = {imm16, 16'h0000};
                id_ex_o.alu_op    = ALU_PASS_B;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.reg_write = 1'b1;
            end
            OP_LW: begin
                id_ex_o.alu_op    = ALU_ADD;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.reg_write = 1'b1;
                id_ex_o.mem_read  = 1'b1;
            end
            OP_SW: begin
                id_ex_o.alu_op    = ALU_ADD;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.mem_write = 1'b1;
            end
            OP_BEQ:  id_ex_o.beq  = 1'b1;
            OP_BNE:  id_ex_o.bne  = 1'b1;
            OP_J:    id_ex_o.jump = 1'b1;
            default: legal = 1'b0;
        endcase

        // Unknown encodings and empty slots go down the pipe as nops
        if (legal && if_id_i.valid) begin
            id_ex_o.valid = 1'b1;
        end else begin
            id_ex_o = '0;
        end
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
    parameter int unsigned NUM_REGS = 32
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  cpu_cfg_pkg::reg_addr_t rs_addr_i,
    input  cpu_cfg_pkg::reg_addr_t rt_addr_i,
    input  isa_pkg::mem_wb_t       wb_i,
    output cpu_cfg_pkg::word_t     rs_data_o,
    output cpu_cfg_pkg::word_t     rt_data_o
);

    import cpu_cfg_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    // Register zero is never written
    assign wr_en = wb_i.valid && wb_i.reg_write && (wb_i.dest != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.dest] <= wb_i.result;
        end
    end

    // Same-cycle write shows through to decode
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && (wb_i.dest == addr)) begin
            value = wb_i.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  isa_pkg::id_ex_t        id_ex_i,
    input  cpu_cfg_pkg::reg_addr_t rs_addr_i,
    input  cpu_cfg_pkg::reg_addr_t rt_addr_i,
    input  logic                   redirect_i,
    input  logic                   mem_stall_i,
    pipe_ctrl_if.hazard            ctrl
);

    logic load_use;

    // Load in execute feeding an operand of the instruction in decode
    assign load_use = id_ex_i.valid && id_ex_i.mem_read && (id_ex_i.dest != '0) &&
                      ((id_ex_i.dest == rs_addr_i) || (id_ex_i.dest == rt_addr_i));

    //////////////////////////////////////////////////
    // Stage controls
    //////////////////////////////////////////////////

    // Memory stall freezes every stage
    assign ctrl.pc_stall    = mem_stall_i || load_use;
    assign ctrl.ifid_stall  = mem_stall_i || load_use;
    assign ctrl.idex_stall  = mem_stall_i;
    assign ctrl.exmem_stall = mem_stall_i;
    assign ctrl.memwb_stall = mem_stall_i;

    // Flushes only fire when the pipe moves
    assign ctrl.ifid_flush  = redirect_i && !mem_stall_i;
    assign ctrl.idex_flush  = load_use && !mem_stall_i;

endmodule

// File: src/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  isa_pkg::id_ex_t    id_ex_i,
    input  isa_pkg::ex_mem_t   ex_mem_i,
    input  isa_pkg::mem_wb_t   mem_wb_i,
    input  cpu_cfg_pkg::word_t wb_data_i,
    output isa_pkg::ex_mem_t   ex_mem_o,
    output logic               redirect_o,
    output cpu_cfg_pkg::word_t target_o
);

    import cpu_cfg_pkg::*;
    import isa_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t alu_res;
    logic  taken;

    // Younger EX/MEM result wins over write-back
    // Loads in EX/MEM are left to the load-use stall
    function automatic word_t forward(input reg_addr_t src, input word_t reg_val);
        word_t value;
        value = reg_val;
        if (src != '0) begin
            if (ex_mem_i.valid && ex_mem_i.reg_write && !ex_mem_i.mem_read &&
                (ex_mem_i.dest == src)) begin
                value = ex_mem_i.result;
            end else if (mem_wb_i.valid && mem_wb_i.reg_write && (mem_wb_i.dest == src)) begin
                value = wb_data_i;
            end
        end
        return value;
    endfunction

    always_comb begin
        src_a = forward(id_ex_i.rs, id_ex_i.op_a);
        src_b = forward(id_ex_i.rt, id_ex_i.op_b);
        alu_b = id_ex_i.use_imm ? id_ex_i.imm : src_b;

        case (id_ex_i.alu_op)
            ALU_ADD: alu_res = src_a + alu_b;
            ALU_SUB: alu_res = src_a - alu_b;
            ALU_AND: alu_res = src_a & alu_b;
            ALU_OR:  alu_res = src_a | alu_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            default: alu_res = alu_b;
        endcase

        ex_mem_o.valid      = id_ex_i.valid;
        ex_mem_o.result     = alu_res;
        ex_mem_o.store_data = src_b;
        ex_mem_o.dest       = id_ex_i.dest;
        ex_mem_o.reg_write  = id_ex_i.reg_write;
        ex_mem_o.mem_read   = id_ex_i.mem_read;
        ex_mem_o.mem_write  = id_ex_i.mem_write;
    end

    //////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////

    assign taken = id_ex_i.jump ||
                   (id_ex_i.beq && (src_a == src_b)) ||
                   (id_ex_i.bne && (src_a != src_b));

    assign redirect_o = id_ex_i.valid && taken;

    assign target_o = id_ex_i.jump ?
                      {id_ex_i.pc_plus4[XLEN-1:XLEN-4], id_ex_i.jump_index, 2'b00} :
                      id_ex_i.pc_plus4 + {id_ex_i.imm[XLEN-3:0], 2'b00};

endmodule

// File: src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter int unsigned NUM_REGS = 32
) (
    input  logic               clk,
    input  logic               arst_n_i,
    output cpu_cfg_pkg::word_t instr_addr_o,
    input  cpu_cfg_pkg::word_t instr_i,
    output cpu_cfg_pkg::word_t data_addr_o,
    output cpu_cfg_pkg::word_t data_wdata_o,
    input  cpu_cfg_pkg::word_t data_rdata_i,
    output logic               data_rd_o,
    output logic               data_wr_o,
    input  logic               mem_stall_i
);

    import cpu_cfg_pkg::*;
    import isa_pkg::*;

    pipe_ctrl_if ctrl ();

    word_t     pc_q;
    word_t     pc_plus4;
    word_t     pc_next;
    word_t     target;
    logic      redirect;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     wb_data;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem_d;
    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_d;
    mem_wb_t   mem_wb_q;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    assign pc_plus4 = pc_q + XLEN'(4);
    assign pc_next  = redirect ? target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!ctrl.pc_stall) begin
            pc_q <= pc_next;
        end
    end

    assign instr_addr_o = pc_q;
    assign if_id_d      = '{valid: 1'b1, instr: instr_i, pc_plus4: pc_plus4};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (ctrl.ifid_stall),
        .flush_i  (ctrl.ifid_flush),
        .d_i      (if_id_d),
        .q_o      (if_id_q)
    );

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign rs_addr = if_id_q.instr[25:21];
    assign rt_addr = if_id_q.instr[20:16];

    reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .wb_i      (mem_wb_q),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    decoder u_decoder (
        .if_id_i   (if_id_q),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .id_ex_o   (id_ex_d)
    );

    hazard_unit u_hazard (
        .id_ex_i     (id_ex_q),
        .rs_addr_i   (rs_addr),
        .rt_addr_i   (rt_addr),
        .redirect_i  (redirect),
        .mem_stall_i (mem_stall_i),
        .ctrl        (ctrl)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (ctrl.idex_stall),
        .flush_i  (ctrl.idex_flush),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    execute_unit u_execute (
        .id_ex_i    (id_ex_q),
        .ex_mem_i   (ex_mem_q),
        .mem_wb_i   (mem_wb_q),
        .wb_data_i  (wb_data),
        .ex_mem_o   (ex_mem_d),
        .redirect_o (redirect),
        .target_o   (target)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (ctrl.exmem_stall),
        .flush_i  (1'b0),
        .d_i      (ex_mem_d),
        .q_o      (ex_mem_q)
    );

    //////////////////////////////////////////////////
    // Memory and write-back
    //////////////////////////////////////////////////

    assign data_addr_o  = ex_mem_q.result;
    assign data_wdata_o = ex_mem_q.store_data;
    assign data_rd_o    = ex_mem_q.valid && ex_mem_q.mem_read;
    assign data_wr_o    = ex_mem_q.valid && ex_mem_q.mem_write;

    // Load data replaces the address for lw
    assign mem_wb_d = '{
        valid:     ex_mem_q.valid,
        result:    ex_mem_q.mem_read ? data_rdata_i : ex_mem_q.result,
        dest:      ex_mem_q.dest,
        reg_write: ex_mem_q.reg_write
    };

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (ctrl.memwb_stall),
        .flush_i  (1'b0),
        .d_i      (mem_wb_d),
        .q_o      (mem_wb_q)
    );

    assign wb_data = mem_wb_q.result;

endmodule

// File: testbench/tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;

    import cpu_cfg_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 8;
    localparam int MAX_STORES   = 64;
    localparam int MAX_INIT     = 32;
    localparam int NUM_TESTS    = 5;

    logic  clk;
    logic  arst_n;
    word_t instr_addr;
    word_t instr;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_rd;
    logic  data_wr;
    logic  mem_stall;

    word_t imem [256];
    word_t dmem [256];
    word_t exp_addr [MAX_STORES];
    word_t exp_data [MAX_STORES];
    int    exp_test [MAX_STORES];
    word_t init_addr [MAX_INIT];
    word_t init_data [MAX_INIT];
    int    n_instr;
    int    n_exp;
    int    n_init;
    int    n_loads;
    int    test_err [1:NUM_TESTS];
    int    stores_seen;
    int    loads_seen;
    bit    stall_run;
    bit    vectors_loaded;

    cpu_top #(.NUM_REGS(32)) u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .instr_addr_o (instr_addr),
        .instr_i      (instr),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata),
        .data_rd_o    (data_rd),
        .data_wr_o    (data_wr),
        .mem_stall_i  (mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////

    assign instr = imem[instr_addr[9:2]];

    // Read data only while the read strobe is up
    assign data_rdata = data_rd ? dmem[data_addr[9:2]] : '0;

    function automatic word_t fill_word(input int idx);
        return {16'hd0d0, 6'b000000, idx[7:0], 2'b00};
    endfunction

    task automatic load_vectors(output bit ok);
        int             fd;
        int             code;
        int             tnum;
        logic [7:0]     tag;
        logic [959:0]   rest;
        word_t          addr;
        word_t          value;
        ok      = 1'b0;
        n_instr = 0;
        n_exp   = 0;
        n_init  = 0;
        n_loads = 0;
        // Unloaded words decode as nops
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        fd = $fopen("testbench/program_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/program_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "I": begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        imem[addr[9:2]] = value;
                        n_instr++;
                        // lw opcode
                        if (value[31:26] == 6'h23) begin
                            n_loads++;
                        end
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        init_addr[n_init] = addr;
                        init_data[n_init] = value;
                        n_init++;
                    end
                    "S": begin
                        code = $fscanf(fd, "%d %h %h", tnum, addr, value);
                        exp_test[n_exp] = tnum;
                        exp_addr[n_exp] = addr;
                        exp_data[n_exp] = value;
                        n_exp++;
                    end
                    default: $display("Unknown line tag in vector file: %s", tag);
                endcase
            end
        end
        $fclose(fd);
        ok = (n_instr > 0) && (n_exp > 0);
    endtask

    // Store order, read count and held outputs under stall
    always @(posedge clk) begin : store_monitor
        int    idx;
        int    reads;
        int    tid;
        logic  stall_prev;
        logic  held_wr;
        word_t held_addr;
        word_t held_wdata;
        if (!arst_n) begin
            idx        = 0;
            reads      = 0;
            stall_prev = 1'b0;
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i);
            end
            for (int i = 0; i < n_init; i++) begin
                dmem[init_addr[i][9:2]] <= init_data[i];
            end
        end else begin
            if (stall_prev) begin
                assert (data_wr == held_wr) else begin
                    $display("ERR data_wr_o under stall: expected %h, got %h", held_wr, data_wr);
                    test_err[5]++;
                end
                assert (data_addr == held_addr) else begin
                    $display("ERR data_addr_o under stall: expected %h, got %h",
                             held_addr, data_addr);
                    test_err[5]++;
                end
                assert (data_wdata == held_wdata) else begin
                    $display("ERR data_wdata_o under stall: expected %h, got %h",
                             held_wdata, data_wdata);
                    test_err[5]++;
                end
            end
            if (data_rd && !mem_stall) begin
                reads++;
            end
            if (data_wr && !mem_stall) begin
                tid = stall_run ? 5 : exp_test[(idx < n_exp) ? idx : n_exp - 1];
                if (idx >= n_exp) begin
                    $display("Unexpected store to %h with data %h after the last expected one",
                             data_addr, data_wdata);
                    test_err[tid]++;
                end else begin
                    assert (data_addr == exp_addr[idx]) else begin
                        $display("ERR data_addr_o store %0d: expected %h, got %h",
                                 idx, exp_addr[idx], data_addr);
                        test_err[tid]++;
                    end
                    assert (data_wdata == exp_data[idx]) else begin
                        $display("ERR data_wdata_o store %0d: expected %h, got %h",
                                 idx, exp_data[idx], data_wdata);
                        test_err[tid]++;
                    end
                end
                dmem[data_addr[9:2]] <= data_wdata;
                idx++;
            end
            stall_prev = mem_stall;
            held_wr    = data_wr;
            held_addr  = data_addr;
            held_wdata = data_wdata;
        end
        stores_seen <= idx;
        loads_seen  <= reads;
    end

    //////////////////////////////////////////////////
    // Sequencing and reporting
    //////////////////////////////////////////////////

    task automatic apply_reset();
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic run_program(input bit with_stalls);
        stall_run <= with_stalls;
        apply_reset();
        while (stores_seen < n_exp) begin
            @(posedge clk);
            mem_stall <= with_stalls && ($urandom % 4 == 0);
        end
        // Let the halt loop run to catch stray stores
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            mem_stall <= 1'b0;
        end
        // Every lw in the image runs exactly once
        assert (loads_seen == n_loads) else begin
            $display("ERR data_rd_o reads: expected %h, got %h", n_loads, loads_seen);
            test_err[with_stalls ? 5 : 3]++;
        end
    endtask

    task automatic report_test(input int num, input string name, inout int failed);
        if (test_err[num] == 0) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, test_err[num]);
            failed++;
        end
    endtask

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (20 * n_instr + 2 * RESET_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish, %0d of %0d stores seen", stores_seen, n_exp);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : sequencer
        bit ok;
        int failed;
        arst_n    = 1'b0;
        mem_stall = 1'b0;
        failed    = 0;
        void'($urandom(48));
        load_vectors(ok);
        if (!ok) begin
            $display("Vector file could not be read or holds no program");
            $display("=== FAIL ===");
        end else begin
            vectors_loaded = 1'b1;
            run_program(1'b0);
            report_test(1, "ALU operations", failed);
            report_test(2, "forwarding and r0", failed);
            report_test(3, "load-use stall", failed);
            report_test(4, "branches and jump", failed);
            run_program(1'b1);
            report_test(5, "random memory stall", failed);
            $display("Tests run: %0d, passed: %0d, failed: %0d",
                     NUM_TESTS, NUM_TESTS - failed, failed);
            if (failed == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
        end
        $finish;
    end

endmodule

// File: files.f
src/cpu_cfg_pkg.sv
src/isa_pkg.sv
src/pipe_ctrl_if.sv
src/pipe_reg.sv
src/decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/execute_unit.sv
src/cpu_top.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the tb_cpu_top simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module tb_cpu_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: testbench/program_vectors.txt
# I byte_address instruction | D byte_address data_word
# S test_number store_address store_data, in program order, all hex except test_number
# test 1 ALU results to 0x200
I 000 24010005
I 004 3C021234
I 008 2403FF0F
I 00C 24140200
I 010 00222021
I 014 00232823
I 018 00653024
I 01C 00453825
I 020 0061402A
I 024 AE840000
I 028 AE850004
I 02C AE860008
I 030 AE87000C
I 034 AE880010
# test 2 back-to-back dependencies and r0
I 038 240A0011
I 03C 254A0100
I 040 014A5821
I 044 016A6023
I 048 24007777
I 04C 000C6821
I 050 AE8B0014
I 054 AE8D0018
I 058 AE80001C
# test 3 load-use
I 05C 24150300
I 060 8EAE0000
I 064 01C17821
I 068 AE8F0020
I 06C 8EB00000
I 070 AE900024
# test 4 branches with delay slots, then halt loop
I 074 10230002
I 078 AE810028
I 07C 14210002
I 080 AE85002C
I 084 114C0002
I 088 AE860030
I 08C AE800060
I 090 14250002
I 094 AE870034
I 098 AE800064
I 09C 0800002A
I 0A0 AE880038
I 0A4 AE800068
I 0A8 0800002A
I 0AC 00000000
D 300 CAFE0042
# test 5 reruns the program under random stall and expects this same sequence
S 1 200 12340005
S 1 204 000000F6
S 1 208 00000006
S 1 20C 123400F6
S 1 210 00000001
S 2 214 00000222
S 2 218 00000111
S 2 21C 00000000
S 3 220 CAFE0047
S 3 224 CAFE0042
S 4 228 00000005
S 4 22C 000000F6
S 4 230 00000006
S 4 234 123400F6
S 4 238 00000001
